// File: rv32_core.f
verilog/rv32_pkg.sv
verilog/ctrl_if.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/mem_align.sv
verilog/pc_unit.sv
verilog/rv32_core.sv
bench/rv32_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rv32_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module rv32_core_tb -f rv32_core.f -o rv32_core_sim

./obj_dir/rv32_core_sim

// File: bench/rv32_core_tb.sv
module rv32_core_tb;

  localparam logic [31:0] RESET_PC   = 32'h8000_0000;
  localparam logic [31:0] DBASE      = 32'h0000_1000;  // x1 points here
  localparam int          IWORDS     = 128;
  localparam int          DWORDS     = 128;
  localparam int          MAX_CYCLES = 500;
  localparam logic [31:0] EBREAK     = 32'h0010_0073;

  localparam int OPC_LUI   = 7'b011_0111;
  localparam int OPC_AUIPC = 7'b001_0111;
  localparam int OPC_JAL   = 7'b110_1111;
  localparam int OPC_JALR  = 7'b110_0111;
  localparam int OPC_LOAD  = 7'b000_0011;
  localparam int OPC_IMM   = 7'b001_0011;
  localparam int OPC_REG   = 7'b011_0011;

  logic        clk;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wmask;
  logic        dmem_we;
  logic        dmem_re;
  logic [31:0] dmem_rdata;
  logic        halt;

  logic [31:0] imem [IWORDS];
  logic [31:0] dmem [DWORDS];
  logic [31:0] iofs;
  logic [31:0] dofs;
  logic [31:0] ebreak_addr;

  logic [31:0] prog [$];      // program table
  logic [31:0] pre_addr [$];  // preset table
  logic [31:0] pre_val [$];
  logic [31:0] exp_addr [$];  // expectation table
  logic [31:0] exp_val [$];
  string       exp_msg [$];

  // load cases on the preset word 7F82_C3A4 as funct3, offset and result
  int          ld_f3 [13]  = '{0, 0, 0, 0, 4, 4, 4, 4, 1, 1, 5, 5, 2};
  int          ld_off [13] = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 2, 0, 2, 0};
  logic [31:0] ld_exp [13] = '{32'hFFFF_FFA4, 32'hFFFF_FFC3, 32'hFFFF_FF82, 32'h0000_007F,
                               32'h0000_00A4, 32'h0000_00C3, 32'h0000_0082, 32'h0000_007F,
                               32'hFFFF_C3A4, 32'h0000_7F82, 32'h0000_C3A4, 32'h0000_7F82,
                               32'h7F82_C3A4};

  // branch cases on x12 = -5, x13 = 3 and x14 = 3
  int br_f3 [12]  = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
  int br_rs1 [12] = '{13, 12, 12, 13, 12, 13, 13, 12, 13, 12, 12, 13};
  int br_rs2 [12] = '{14, 13, 13, 14, 13, 12, 12, 13, 12, 13, 13, 12};

  rv32_core #(
    .RESET_PC (RESET_PC)
  ) uut (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  always #4 clk = ~clk;

  // zero-wait memories, data answers only while dmem_re is high
  assign iofs       = imem_addr - RESET_PC;
  assign imem_rdata = (iofs < 4 * IWORDS) ? imem[iofs[8:2]] : 32'h0;
  assign dofs       = dmem_addr - DBASE;
  assign dmem_rdata = (dmem_re && dofs < 4 * DWORDS) ? dmem[dofs[8:2]] : 32'h0;

  task automatic fail_run(string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check(logic [31:0] got, logic [31:0] want, string msg);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, got, want);
      $display("*** FAILED ***");
      $fatal(1, "stopping at first error");
    end
  endtask

  always @(posedge clk) begin
    if (dmem_we && dmem_wmask != 4'b0000) begin
      if (dofs >= 4 * DWORDS) begin
        fail_run($sformatf("store to %h lies outside data memory", dmem_addr));
      end
      for (int b = 0; b < 4; b++) begin
        if (dmem_wmask[b]) dmem[dofs[8:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
    end
  end

  // RV32 encoders
  function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_REG[6:0]};
  endfunction

  function automatic logic [31:0] enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b010_0011};
  endfunction

  function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b110_0011};
  endfunction

  function automatic logic [31:0] enc_u(int imm, int rd, int op);
    return {imm[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL[6:0]};
  endfunction

  function automatic logic [31:0] next_addr();
    return RESET_PC + 32'(4 * prog.size());
  endfunction

  function automatic logic branch_taken(int f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      0:       return a == b;
      1:       return a != b;
      4:       return $signed(a) < $signed(b);
      5:       return $signed(a) >= $signed(b);
      6:       return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] reg_value(int idx);
    return (idx == 12) ? 32'hFFFF_FFFB : 32'd3;
  endfunction

  task automatic emit(logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic addi(int rd, int rs1, int imm);
    emit(enc_i(imm, rs1, 0, rd, OPC_IMM));
  endtask

  task automatic expect_word(int ofs, logic [31:0] want, string msg);
    exp_addr.push_back(DBASE + 32'(ofs));
    exp_val.push_back(want);
    exp_msg.push_back(msg);
  endtask

  // sw rs2 to x1 + ofs and expect the word there
  task automatic store_check(int rs2, int ofs, logic [31:0] want, string msg);
    emit(enc_s(ofs, rs2, 1, 2));
    expect_word(ofs, want, msg);
  endtask

  task automatic preset(int ofs, logic [31:0] val);
    pre_addr.push_back(DBASE + 32'(ofs));
    pre_val.push_back(val);
  endtask

  task automatic build_program();
    logic [31:0] a;
    int          tag;
    emit(enc_u(1, 1, OPC_LUI));            // x1 = 0x1000
    addi(2, 0, 100);
    addi(3, 0, -7);
    emit(enc_r(0, 3, 2, 0, 4));            // add x4
    emit(enc_r(32, 3, 2, 0, 5));           // sub x5
    emit(enc_u(20'hABCDE, 6, OPC_LUI));
    a = next_addr();
    emit(enc_u(20'h00010, 7, OPC_AUIPC));
    store_check(2, 'h00, 32'd100, "addi positive");
    store_check(3, 'h04, 32'hFFFF_FFF9, "addi negative");
    store_check(4, 'h08, 32'd93, "add");
    store_check(5, 'h0C, 32'd107, "sub");
    store_check(6, 'h10, 32'hABCD_E000, "lui");
    store_check(7, 'h14, a + 32'h0001_0000, "auipc");

    preset('h40, 32'h7F82_C3A4);
    for (int k = 0; k < 13; k++) begin
      emit(enc_i('h40 + ld_off[k], 1, ld_f3[k], 8, OPC_LOAD));
      store_check(8, 'h80 + 4 * k, ld_exp[k],
                  $sformatf("load funct3 %0d offset %0d", ld_f3[k], ld_off[k]));
    end

    addi(9, 0, 'h5C);
    addi(10, 0, -'h2DC);                   // low half FD24
    for (int k = 0; k < 6; k++) begin
      preset('hC0 + 4 * k, 32'hAAAA_AAAA);
    end
    for (int k = 0; k < 4; k++) begin
      emit(enc_s('hC0 + 5 * k, 9, 1, 0)); // sb at offset k
    end
    emit(enc_s('hD0, 10, 1, 1));
    emit(enc_s('hD6, 10, 1, 1));
    expect_word('hC0, 32'hAAAA_AA5C, "sb offset 0");
    expect_word('hC4, 32'hAAAA_5CAA, "sb offset 1");
    expect_word('hC8, 32'hAA5C_AAAA, "sb offset 2");
    expect_word('hCC, 32'h5CAA_AAAA, "sb offset 3");
    expect_word('hD0, 32'hAAAA_FD24, "sh offset 0");
    expect_word('hD4, 32'hFD24_AAAA, "sh offset 2");

    addi(12, 0, -5);
    addi(13, 0, 3);
    addi(14, 0, 3);
    for (int k = 0; k < 12; k++) begin
      tag = (k + 1) * 16;
      addi(11, 0, tag + 1);
      emit(enc_b(8, br_rs2[k], br_rs1[k], br_f3[k]));
      addi(11, 0, tag + 2);                // skipped when taken
      store_check(11, 'h100 + 4 * k,
                  branch_taken(br_f3[k], reg_value(br_rs1[k]), reg_value(br_rs2[k]))
                    ? 32'(tag + 1) : 32'(tag + 2),
                  $sformatf("branch funct3 %0d case %0d", br_f3[k], k));
    end

    addi(16, 0, 1);
    a = next_addr();
    emit(enc_j(8, 15));
    addi(16, 0, 2);
    store_check(15, 'h130, a + 32'd4, "jal link");
    store_check(16, 'h134, 32'd1, "jal path");
    a = next_addr();
    emit(enc_u(0, 17, OPC_AUIPC));         // x17 = own address
    addi(16, 0, 3);
    emit(enc_i(16, 17, 0, 18, OPC_JALR));
    addi(16, 0, 4);
    store_check(18, 'h138, a + 32'd12, "jalr link");
    store_check(16, 'h13C, 32'd3, "jalr path");

    preset('h140, 32'hDEAD_BEEF);
    addi(0, 0, 55);
    store_check(0, 'h140, 32'h0, "x0 stays zero");
    preset('h144, 32'hCAFE_F00D);
    ebreak_addr = next_addr();
    emit(EBREAK);
    store_check(2, 'h144, 32'hCAFE_F00D, "sentinel after ebreak");
  endtask

  initial begin
    int cycles;
    clk = 1'b0;
    rst = 1'b1;
    build_program();
    for (int i = 0; i < IWORDS; i++) begin
      imem[i] = enc_i(i, 0, 0, 0, OPC_IMM);
    end
    for (int i = 0; i < prog.size(); i++) begin
      imem[i] = prog[i];
    end
    for (int i = 0; i < DWORDS; i++) begin
      dmem[i] = ~(DBASE + 32'(4 * i));   // address-dependent fill
    end
    for (int i = 0; i < pre_addr.size(); i++) begin
      dmem[(pre_addr[i] - DBASE) >> 2] = pre_val[i];
    end

    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    check({31'b0, halt}, 32'd0, "halt low after reset");

    cycles = 0;
    while (!halt && cycles < MAX_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!halt) fail_run("halt never rose within the cycle limit");

    for (int i = 0; i < 10; i++) begin  // core must stay frozen
      @(posedge clk);
      #1;
      check({31'b0, halt}, 32'd1, "halt stays high");
      check(imem_addr, ebreak_addr, "pc holds the ebreak address");
    end

    for (int i = 0; i < exp_addr.size(); i++) begin
      check(dmem[(exp_addr[i] - DBASE) >> 2], exp_val[i], exp_msg[i]);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: verilog/rv32_core.sv
module rv32_core #(
  parameter logic [rv32_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic                        clk,
  input  logic                        rst,
  output logic [rv32_pkg::XLEN-1:0]   imem_addr,
  input  logic [rv32_pkg::INSN_W-1:0] imem_rdata,
  output logic [rv32_pkg::XLEN-1:0]   dmem_addr,
  output logic [rv32_pkg::XLEN-1:0]   dmem_wdata,
  output logic [rv32_pkg::MASK_W-1:0] dmem_wmask,
  output logic                        dmem_we,
  output logic                        dmem_re,
  input  logic [rv32_pkg::XLEN-1:0]   dmem_rdata,
  output logic                        halt
);

  logic [rv32_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [rv32_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [rv32_pkg::REG_ADDR_W-1:0] rd_addr;
  logic [rv32_pkg::XLEN-1:0]       rs1_data;
  logic [rv32_pkg::XLEN-1:0]       rs2_data;
  logic [rv32_pkg::XLEN-1:0]       alu_out;  // data address and jump target
  logic [rv32_pkg::XLEN-1:0]       wb_data;
  logic [rv32_pkg::XLEN-1:0]       load_data;
  logic [rv32_pkg::XLEN-1:0]       pc;
  logic [rv32_pkg::XLEN-1:0]       link;
  logic                            take_branch;
  logic                            active;
  logic                            ebreak;

  ctrl_if ctrl ();

  decoder u_decoder (
    .insn     (imem_rdata),
    .active   (active),
    .ctrl     (ctrl.dec),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .ebreak   (ebreak)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .we       (ctrl.reg_we),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit u_exec_unit (
    .ctrl        (ctrl.exe),
    .pc          (pc),
    .link        (link),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .load_data   (load_data),
    .alu_out     (alu_out),
    .take_branch (take_branch),
    .wb_data     (wb_data)
  );

  mem_align u_mem_align (
    .ctrl      (ctrl.mem),
    .addr_low  (alu_out[1:0]),
    .rs2_data  (rs2_data),
    .rdata     (dmem_rdata),
    .load_data (load_data),
    .wdata     (dmem_wdata),
    .wmask     (dmem_wmask),
    .re        (dmem_re),
    .we        (dmem_we)
  );

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .take_branch (take_branch),
    .is_jump     (ctrl.is_jump),
    .target      (alu_out),
    .ebreak      (ebreak),
    .pc          (pc),
    .link        (link),
    .active      (active),
    .halt        (halt)
  );

  assign imem_addr = pc;      // fetch straight from the pc
  assign dmem_addr = alu_out;

endmodule

// File: verilog/pc_unit.sv
module pc_unit #(
  parameter logic [rv32_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      take_branch,
  input  logic                      is_jump,
  input  logic [rv32_pkg::XLEN-1:0] target,
  input  logic                      ebreak,
  output logic [rv32_pkg::XLEN-1:0] pc,
  output logic [rv32_pkg::XLEN-1:0] link,
  output logic                      active,
  output logic                      halt
);

  logic [rv32_pkg::XLEN-1:0] next_pc;

  assign link   = pc + 32'd4;
  assign active = !rst && !halt;

  always_comb begin
    if (take_branch) begin
      next_pc = target;
    end else if (is_jump) begin
      next_pc = {target[rv32_pkg::XLEN-1:1], 1'b0}; // jalr clears bit 0
    end else begin
      next_pc = link;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= RESET_PC;
      halt <= 1'b0;
    end else if (active) begin
      if (ebreak) begin
        halt <= 1'b1;   // pc stays on the ebreak
      end else begin
        pc <= next_pc;
      end
    end
  end

endmodule

// File: verilog/mem_align.sv
module mem_align (
  ctrl_if.mem                         ctrl,
  input  logic [1:0]                  addr_low,
  input  logic [rv32_pkg::XLEN-1:0]   rs2_data,
  input  logic [rv32_pkg::XLEN-1:0]   rdata,
  output logic [rv32_pkg::XLEN-1:0]   load_data,
  output logic [rv32_pkg::XLEN-1:0]   wdata,
  output logic [rv32_pkg::MASK_W-1:0] wmask,
  output logic                        re,
  output logic                        we
);

  logic [7:0]                  byte_sel;
  logic [15:0]                 half_sel;
  logic [rv32_pkg::MASK_W-1:0] mask_raw;

  // lane pick from the read word
  assign byte_sel = rdata[{addr_low, 3'b000} +: 8];
  assign half_sel = addr_low[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (ctrl.funct3)
      rv32_pkg::F3_B:  load_data = {{24{byte_sel[7]}}, byte_sel};
      rv32_pkg::F3_H:  load_data = {{16{half_sel[15]}}, half_sel};
      rv32_pkg::F3_BU: load_data = {24'h0, byte_sel};
      rv32_pkg::F3_HU: load_data = {16'h0, half_sel};
      default:         load_data = rdata; // lw
    endcase
  end

  // store data copied into every lane while the mask picks the live one
  always_comb begin
    case (ctrl.funct3)
      rv32_pkg::F3_B: begin
        wdata    = {4{rs2_data[7:0]}};
        mask_raw = 4'b0001 << addr_low;
      end
      rv32_pkg::F3_H: begin
        wdata = {2{rs2_data[15:0]}};
        if (addr_low[0]) begin
          mask_raw = 4'b0000;  // misaligned half
        end else begin
          mask_raw = addr_low[1] ? 4'b1100 : 4'b0011;
        end
      end
      rv32_pkg::F3_W: begin
        wdata    = rs2_data;
        mask_raw = (addr_low == 2'b00) ? 4'b1111 : 4'b0000;
      end
      default: begin
        wdata    = rs2_data;
        mask_raw = 4'b0000;
      end
    endcase
  end

  assign wmask = ctrl.mem_we ? mask_raw : '0;
  assign re    = ctrl.mem_re;
  assign we    = ctrl.mem_we;

endmodule

// File: verilog/exec_unit.sv
module exec_unit (
  ctrl_if.exe                       ctrl,
  input  logic [rv32_pkg::XLEN-1:0] pc,
  input  logic [rv32_pkg::XLEN-1:0] link,
  input  logic [rv32_pkg::XLEN-1:0] rs1_data,
  input  logic [rv32_pkg::XLEN-1:0] rs2_data,
  input  logic [rv32_pkg::XLEN-1:0] load_data,
  output logic [rv32_pkg::XLEN-1:0] alu_out,
  output logic                      take_branch,
  output logic [rv32_pkg::XLEN-1:0] wb_data
);

  localparam int MSB = rv32_pkg::XLEN - 1;

  logic [MSB:0] op_a;
  logic [MSB:0] op_b;
  logic [MSB+1:0] diff;   // extra bit is the unsigned borrow
  logic         eq;
  logic         lt;
  logic         ltu;
  logic         cond;

  assign op_a = (ctrl.src_a == rv32_pkg::SRC_A_PC)  ? pc       : rs1_data;
  assign op_b = (ctrl.src_b == rv32_pkg::SRC_B_IMM) ? ctrl.imm : rs2_data;

  // address, jump target and arithmetic result
  assign alu_out = ctrl.sub ? (op_a - op_b) : (op_a + op_b);

  // compare runs beside the adder since the adder makes the branch target
  assign diff = {1'b0, rs1_data} - {1'b0, rs2_data};
  assign eq   = (diff[MSB:0] == '0);
  assign ltu  = diff[MSB+1];
  assign lt   = (rs1_data[MSB] != rs2_data[MSB]) ? rs1_data[MSB] : diff[MSB];

  always_comb begin
    case (ctrl.funct3)
      rv32_pkg::F3_BEQ:  cond = eq;
      rv32_pkg::F3_BNE:  cond = !eq;
      rv32_pkg::F3_BLT:  cond = lt;
      rv32_pkg::F3_BGE:  cond = !lt;
      rv32_pkg::F3_BLTU: cond = ltu;
      rv32_pkg::F3_BGEU: cond = !ltu;
      default:           cond = 1'b0; // 010/011 are reserved
    endcase
  end

  assign take_branch = ctrl.is_branch & cond;

  always_comb begin
    case (ctrl.wb_sel)
      rv32_pkg::WB_LINK: wb_data = link;
      rv32_pkg::WB_LOAD: wb_data = load_data;
      default:           wb_data = alu_out;
    endcase
  end

endmodule

// File: verilog/reg_file.sv
module reg_file (
  input  logic                            clk,
  input  logic [rv32_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  logic [rv32_pkg::REG_ADDR_W-1:0] rs2_addr,
  input  logic [rv32_pkg::REG_ADDR_W-1:0] rd_addr,
  input  logic                            we,
  input  logic [rv32_pkg::XLEN-1:0]       wdata,
  output logic [rv32_pkg::XLEN-1:0]       rs1_data,
  output logic [rv32_pkg::XLEN-1:0]       rs2_data
);

  // x0 has no storage
  logic [rv32_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (we && (rd_addr != '0)) begin
      regs[rd_addr] <= wdata;
    end
  end

  // asynchronous reads
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (rs1_addr != '0) begin
      rs1_data = regs[rs1_addr];
    end
    if (rs2_addr != '0) begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

// File: verilog/decoder.sv
module decoder (
  input  logic [rv32_pkg::INSN_W-1:0]     insn,
  input  logic                            active,
  ctrl_if.dec                             ctrl,
  output logic [rv32_pkg::REG_ADDR_W-1:0] rs1_addr,
  output logic [rv32_pkg::REG_ADDR_W-1:0] rs2_addr,
  output logic [rv32_pkg::REG_ADDR_W-1:0] rd_addr,
  output logic                            ebreak
);

  localparam logic [rv32_pkg::INSN_W-1:0] EBREAK_WORD = 32'h0010_0073;

  rv32_pkg::opcode_e         opcode;
  logic [2:0]                funct3;
  logic [rv32_pkg::XLEN-1:0] imm_i;
  logic [rv32_pkg::XLEN-1:0] imm_s;
  logic [rv32_pkg::XLEN-1:0] imm_b;
  logic [rv32_pkg::XLEN-1:0] imm_u;
  logic [rv32_pkg::XLEN-1:0] imm_j;
  logic                      reg_we_raw;
  logic                      mem_re_raw;
  logic                      mem_we_raw;

  assign opcode   = rv32_pkg::opcode_e'(insn[6:0]);
  assign funct3   = insn[14:12];
  assign rs2_addr = insn[24:20];
  assign rd_addr  = insn[11:7];
  // lui is x0 + imm since its rs1 field holds immediate bits
  assign rs1_addr = (opcode == rv32_pkg::OP_LUI) ? '0 : insn[19:15];
  assign ebreak   = (insn == EBREAK_WORD);

  // sign-extended immediates per format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    ctrl.src_a     = rv32_pkg::SRC_A_RS1;
    ctrl.src_b     = rv32_pkg::SRC_B_IMM;
    ctrl.wb_sel    = rv32_pkg::WB_ALU;
    ctrl.sub       = 1'b0;
    ctrl.is_branch = 1'b0;
    ctrl.is_jump   = 1'b0;
    ctrl.imm       = imm_i;
    reg_we_raw     = 1'b0;
    mem_re_raw     = 1'b0;
    mem_we_raw     = 1'b0;
    case (opcode)
      rv32_pkg::OP_LUI: begin
        ctrl.imm   = imm_u;
        reg_we_raw = 1'b1;
      end
      rv32_pkg::OP_AUIPC: begin
        ctrl.src_a = rv32_pkg::SRC_A_PC;
        ctrl.imm   = imm_u;
        reg_we_raw = 1'b1;
      end
      rv32_pkg::OP_JAL: begin
        ctrl.src_a   = rv32_pkg::SRC_A_PC;
        ctrl.imm     = imm_j;
        ctrl.wb_sel  = rv32_pkg::WB_LINK;
        ctrl.is_jump = 1'b1;
        reg_we_raw   = 1'b1;
      end
      rv32_pkg::OP_JALR: begin
        ctrl.wb_sel  = rv32_pkg::WB_LINK; // target is rs1 + imm_i
        ctrl.is_jump = 1'b1;
        reg_we_raw   = 1'b1;
      end
      rv32_pkg::OP_BRANCH: begin
        ctrl.src_a     = rv32_pkg::SRC_A_PC;
        ctrl.imm       = imm_b;
        ctrl.is_branch = 1'b1;
      end
      rv32_pkg::OP_LOAD: begin
        ctrl.wb_sel = rv32_pkg::WB_LOAD;
        reg_we_raw  = 1'b1;
        mem_re_raw  = 1'b1;
      end
      rv32_pkg::OP_STORE: begin
        ctrl.imm   = imm_s;
        mem_we_raw = 1'b1;
      end
      rv32_pkg::OP_IMM: reg_we_raw = (funct3 == 3'b000); // addi only
      rv32_pkg::OP_REG: begin
        ctrl.src_b = rv32_pkg::SRC_B_RS2;
        ctrl.sub   = insn[30];
        // add and sub need the other funct7 bits clear
        reg_we_raw = (funct3 == 3'b000) && ({insn[31], insn[29:25]} == 6'b0);
      end
      default: ;  // ebreak and unknown words write nothing
    endcase
  end

  assign ctrl.funct3 = funct3;
  assign ctrl.reg_we = reg_we_raw & active;
  assign ctrl.mem_re = mem_re_raw & active;
  assign ctrl.mem_we = mem_we_raw & active;

endmodule

// File: verilog/ctrl_if.sv
interface ctrl_if;

  rv32_pkg::src_a_e            src_a;
  rv32_pkg::src_b_e            src_b;
  rv32_pkg::wb_sel_e           wb_sel;
  logic                        sub;     // adder subtracts
  logic                        reg_we;
  logic                        mem_re;
  logic                        mem_we;
  logic                        is_branch;
  logic                        is_jump; // jal or jalr
  logic [2:0]                  funct3;
  logic [rv32_pkg::XLEN-1:0]   imm;

  modport dec (
    output src_a, src_b, wb_sel, sub, reg_we, mem_re, mem_we,
    output is_branch, is_jump, funct3, imm
  );

  // operand, branch and write-back side
  modport exe (
    input src_a, src_b, wb_sel, sub, is_branch, funct3, imm
  );

  modport mem (
    input mem_re, mem_we, funct3
  );

endinterface

// File: verilog/rv32_pkg.sv
package rv32_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int MASK_W     = 4;
  localparam int INSN_W     = 32;

  // major opcodes in insn[6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b011_0111,
    OP_AUIPC  = 7'b001_0111,
    OP_JAL    = 7'b110_1111,
    OP_JALR   = 7'b110_0111,
    OP_BRANCH = 7'b110_0011,
    OP_LOAD   = 7'b000_0011,
    OP_STORE  = 7'b010_0011,
    OP_IMM    = 7'b001_0011,
    OP_REG    = 7'b011_0011,
    OP_SYSTEM = 7'b111_0011
  } opcode_e;

  // load widths where stores reuse B, H and W
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef enum logic {
    SRC_A_RS1 = 1'b0,
    SRC_A_PC  = 1'b1
  } src_a_e;

  typedef enum logic {
    SRC_B_RS2 = 1'b0,
    SRC_B_IMM = 1'b1
  } src_b_e;

  // write-back source for rd
  typedef enum logic [1:0] {
    WB_ALU  = 2'b00,
    WB_LINK = 2'b01,
    WB_LOAD = 2'b10
  } wb_sel_e;

endpackage
